// ==== source/bev_macros.svh ====
`ifndef BEV_MACROS_SVH
`define BEV_MACROS_SVH

// field widths of the barrel record
`define BEV_ING_W   12
`define BEV_MONTH_W 4
`define BEV_DAY_W   5
`define BEV_ADDR_W  8

// total cup volume per size
`define BEV_CUP_L 12'd960
`define BEV_CUP_M 12'd720
`define BEV_CUP_S 12'd480

`endif

// ==== source/bev_pkg.sv ====
`include "bev_macros.svh"

package bev_pkg;

    typedef logic [`BEV_ING_W-1:0]   ing_t;
    typedef logic [`BEV_MONTH_W-1:0] month_t;
    typedef logic [`BEV_DAY_W-1:0]   day_t;
    typedef logic [`BEV_ADDR_W-1:0]  box_no_t;

    typedef struct packed {
        month_t month;
        day_t   day;
    } date_t;

    // codes 1 and 3 are not served
    typedef enum logic [1:0] {
        make_drink       = 2'd0,
        check_valid_date = 2'd2
    } action_t;

    typedef enum logic [2:0] {
        black_tea,
        milk_tea,
        extra_milk_tea,
        green_tea,
        green_milk_tea,
        pineapple_juice,
        super_pineapple_tea,
        super_pineapple_milk_tea
    } bev_type_t;

    typedef enum logic [1:0] {size_l, size_m, size_s} bev_size_t;

    typedef enum logic [1:0] {no_err, no_exp, no_ing} err_msg_t;

    typedef struct packed {
        ing_t black_tea;
        ing_t green_tea;
        ing_t milk;
        ing_t pineapple;
    } recipe_t;

    // memory layout from the msb down
    typedef struct packed {
        ing_t       black_tea;
        ing_t       green_tea;
        logic [3:0] pad_m;
        month_t     month;
        ing_t       milk;
        ing_t       pineapple;
        logic [2:0] pad_d;
        day_t       day;
    } barrel_t;

    typedef enum logic [2:0] {
        idle,
        collect,
        read_wait,
        judge,
        write_wait,
        respond
    } ctrl_state_t;

endpackage

// ==== source/bev_order_intake.sv ====
`timescale 1ns/1ns
`include "bev_macros.svh"

module bev_order_intake (
    input  logic               clk,
    input  logic               inf,
    input  logic               type_valid,
    input  bev_pkg::bev_type_t bev_type,
    input  logic               size_valid,
    input  bev_pkg::bev_size_t bev_size,
    input  logic               date_valid,
    input  bev_pkg::date_t     date,
    input  logic               box_no_valid,
    input  bev_pkg::box_no_t   box_no,
    output bev_pkg::date_t     order_date,
    output bev_pkg::box_no_t   order_box,
    output bev_pkg::recipe_t   need
);

    bev_pkg::bev_type_t type_q;
    bev_pkg::ing_t      cup;
    bev_pkg::ing_t      half;
    bev_pkg::ing_t      quarter;
    bev_pkg::ing_t      three_q;
    bev_pkg::recipe_t   need_nxt;

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            type_q     <= bev_pkg::black_tea;
            order_date <= '0;
            order_box  <= '0;
        end else begin
            if (type_valid)
                type_q <= bev_type;
            if (date_valid)
                order_date <= date;
            if (box_no_valid)
                order_box <= box_no;
        end
    end

    always_comb begin
        case (bev_size)
            bev_pkg::size_l: cup = `BEV_CUP_L;
            bev_pkg::size_m: cup = `BEV_CUP_M;
            default:         cup = `BEV_CUP_S;
        endcase
    end

    // all cup sizes divide by four exactly
    assign half    = cup >> 1;
    assign quarter = cup >> 2;
    assign three_q = cup - quarter;

    // type is already held when size arrives
    always_comb begin
        need_nxt = '0;
        case (type_q)
            bev_pkg::black_tea: need_nxt.black_tea = cup;
            bev_pkg::milk_tea: begin
                need_nxt.black_tea = three_q;
                need_nxt.milk      = quarter;
            end
            bev_pkg::extra_milk_tea: begin
                need_nxt.black_tea = half;
                need_nxt.milk      = half;
            end
            bev_pkg::green_tea: need_nxt.green_tea = cup;
            bev_pkg::green_milk_tea: begin
                need_nxt.green_tea = half;
                need_nxt.milk      = half;
            end
            bev_pkg::pineapple_juice: need_nxt.pineapple = cup;
            bev_pkg::super_pineapple_tea: begin
                need_nxt.black_tea = half;
                need_nxt.pineapple = half;
            end
            default: begin
                need_nxt.black_tea = half;
                need_nxt.milk      = quarter;
                need_nxt.pineapple = quarter;
            end
        endcase
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf)
            need <= '0;
        else if (size_valid)
            need <= need_nxt;
    end

endmodule

// ==== source/bev_barrel_calc.sv ====
`timescale 1ns/1ns
`include "bev_macros.svh"

module bev_barrel_calc (
    input  logic             clk,
    input  logic             inf,
    input  logic             barrel_load,
    input  bev_pkg::barrel_t c_data_r,
    input  bev_pkg::date_t   order_date,
    input  bev_pkg::recipe_t need,
    output logic             expired,
    output logic             short,
    output bev_pkg::barrel_t c_data_w
);

    bev_pkg::barrel_t      bar_q;
    logic                  loaded;
    logic [`BEV_ING_W:0]   bt_rem;
    logic [`BEV_ING_W:0]   gt_rem;
    logic [`BEV_ING_W:0]   mk_rem;
    logic [`BEV_ING_W:0]   pa_rem;

    always_ff @(posedge clk) begin
        if (barrel_load)
            bar_q <= c_data_r;
    end

    // marks that bar_q holds a real record
    always_ff @(posedge clk or negedge inf) begin
        if (!inf)
            loaded <= 1'b0;
        else if (barrel_load)
            loaded <= 1'b1;
    end

    // top bit of each remainder is the borrow
    assign bt_rem = {1'b0, bar_q.black_tea} - {1'b0, need.black_tea};
    assign gt_rem = {1'b0, bar_q.green_tea} - {1'b0, need.green_tea};
    assign mk_rem = {1'b0, bar_q.milk} - {1'b0, need.milk};
    assign pa_rem = {1'b0, bar_q.pineapple} - {1'b0, need.pineapple};

    assign short = bt_rem[`BEV_ING_W] | gt_rem[`BEV_ING_W] |
                   mk_rem[`BEV_ING_W] | pa_rem[`BEV_ING_W];

    // month first and the day only on a tie
    assign expired = (order_date.month > bar_q.month) ||
                     (order_date.month == bar_q.month && order_date.day > bar_q.day);

    always_comb begin
        c_data_w           = '0;
        c_data_w.black_tea = bt_rem[`BEV_ING_W-1:0];
        c_data_w.green_tea = gt_rem[`BEV_ING_W-1:0];
        c_data_w.milk      = mk_rem[`BEV_ING_W-1:0];
        c_data_w.pineapple = pa_rem[`BEV_ING_W-1:0];
        c_data_w.month     = bar_q.month;
        c_data_w.day       = bar_q.day;
    end

    a_short_only_when_lacking: assert property (@(posedge clk) disable iff (!inf)
        (loaded && bar_q.black_tea >= need.black_tea && bar_q.green_tea >= need.green_tea &&
         bar_q.milk >= need.milk && bar_q.pineapple >= need.pineapple) |-> !short)
        else $error("short raised while stock covers the recipe");

endmodule

// ==== source/bev_control.sv ====
`timescale 1ns/1ns

module bev_control (
    input  logic              clk,
    input  logic              inf,
    input  logic              sel_action_valid,
    input  bev_pkg::action_t  action,
    input  logic              box_no_valid,
    input  logic              c_out_valid,
    input  logic              expired,
    input  logic              short,
    output logic              barrel_load,
    output logic              c_in_valid,
    output logic              c_r_wb,
    output logic              out_valid,
    output bev_pkg::err_msg_t err_msg,
    output logic              complete
);

    bev_pkg::ctrl_state_t state;
    bev_pkg::ctrl_state_t state_nxt;
    bev_pkg::action_t     act_q;
    bev_pkg::err_msg_t    verdict;
    logic                 make_ok;
    logic                 write_done;
    logic                 resp_go;
    logic                 act_kept;

    assign act_kept = (action == bev_pkg::make_drink) || (action == bev_pkg::check_valid_date);

    // expiry beats shortage and a check only sees expiry
    always_comb begin
        verdict = bev_pkg::no_err;
        if (expired)
            verdict = bev_pkg::no_exp;
        else if (act_q == bev_pkg::make_drink && short)
            verdict = bev_pkg::no_ing;
    end

    assign make_ok     = (act_q == bev_pkg::make_drink) && (verdict == bev_pkg::no_err);
    assign write_done  = (state == bev_pkg::write_wait) && c_out_valid;
    assign resp_go     = ((state == bev_pkg::judge) && !make_ok) || write_done;
    assign barrel_load = (state == bev_pkg::read_wait) && c_out_valid;

    always_comb begin
        state_nxt = state;
        case (state)
            bev_pkg::idle:
                if (sel_action_valid && act_kept)
                    state_nxt = bev_pkg::collect;
            bev_pkg::collect:
                if (box_no_valid)
                    state_nxt = bev_pkg::read_wait;
            bev_pkg::read_wait:
                if (c_out_valid)
                    state_nxt = bev_pkg::judge;
            bev_pkg::judge:
                state_nxt = make_ok ? bev_pkg::write_wait : bev_pkg::respond;
            bev_pkg::write_wait:
                if (c_out_valid)
                    state_nxt = bev_pkg::respond;
            default:
                state_nxt = bev_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            state <= bev_pkg::idle;
            act_q <= bev_pkg::make_drink;
        end else begin
            state <= state_nxt;
            if (state == bev_pkg::idle && sel_action_valid && act_kept)
                act_q <= action;
        end
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            c_in_valid <= 1'b0;
            c_r_wb     <= 1'b1;
            out_valid  <= 1'b0;
            err_msg    <= bev_pkg::no_err;
            complete   <= 1'b0;
        end else begin
            c_in_valid <= ((state == bev_pkg::collect) && box_no_valid) ||
                          ((state == bev_pkg::judge) && make_ok);
            // low only for the write-back
            if ((state == bev_pkg::judge) && make_ok)
                c_r_wb <= 1'b0;
            else if (write_done)
                c_r_wb <= 1'b1;
            out_valid <= resp_go;
            err_msg   <= ((state == bev_pkg::judge) && !make_ok) ? verdict : bev_pkg::no_err;
            complete  <= resp_go && (write_done || verdict == bev_pkg::no_err);
        end
    end

    a_req_single_cycle: assert property (@(posedge clk) disable iff (!inf)
        c_in_valid |=> !c_in_valid)
        else $error("memory request held two cycles");

    a_resp_not_with_req: assert property (@(posedge clk) disable iff (!inf)
        !(out_valid && c_in_valid))
        else $error("response pulse overlaps a memory request");

endmodule

// ==== source/bev_top.sv ====
`timescale 1ns/1ns

module bev_top (
    input  logic               clk,
    input  logic               inf,
    input  logic               sel_action_valid,
    input  bev_pkg::action_t   action,
    input  logic               type_valid,
    input  bev_pkg::bev_type_t bev_type,
    input  logic               size_valid,
    input  bev_pkg::bev_size_t bev_size,
    input  logic               date_valid,
    input  bev_pkg::date_t     date,
    input  logic               box_no_valid,
    input  bev_pkg::box_no_t   box_no,
    output logic               c_in_valid,
    output bev_pkg::box_no_t   c_addr,
    output logic               c_r_wb,
    output bev_pkg::barrel_t   c_data_w,
    input  logic               c_out_valid,
    input  bev_pkg::barrel_t   c_data_r,
    output logic               out_valid,
    output bev_pkg::err_msg_t  err_msg,
    output logic               complete
);

    bev_pkg::date_t   order_date;
    bev_pkg::box_no_t order_box;
    bev_pkg::recipe_t need;
    logic             barrel_load;
    logic             expired;
    logic             short;

    assign c_addr = order_box;

    bev_order_intake u_intake (
        .clk          (clk),
        .inf          (inf),
        .type_valid   (type_valid),
        .bev_type     (bev_type),
        .size_valid   (size_valid),
        .bev_size     (bev_size),
        .date_valid   (date_valid),
        .date         (date),
        .box_no_valid (box_no_valid),
        .box_no       (box_no),
        .order_date   (order_date),
        .order_box    (order_box),
        .need         (need)
    );

    bev_barrel_calc u_calc (
        .clk         (clk),
        .inf         (inf),
        .barrel_load (barrel_load),
        .c_data_r    (c_data_r),
        .order_date  (order_date),
        .need        (need),
        .expired     (expired),
        .short       (short),
        .c_data_w    (c_data_w)
    );

    bev_control u_ctrl (
        .clk              (clk),
        .inf              (inf),
        .sel_action_valid (sel_action_valid),
        .action           (action),
        .box_no_valid     (box_no_valid),
        .c_out_valid      (c_out_valid),
        .expired          (expired),
        .short            (short),
        .barrel_load      (barrel_load),
        .c_in_valid       (c_in_valid),
        .c_r_wb           (c_r_wb),
        .out_valid        (out_valid),
        .err_msg          (err_msg),
        .complete         (complete)
    );

endmodule

// ==== sim/bev_checker.sv ====
`timescale 1ns/1ns

module bev_checker (
    input  logic               clk,
    input  logic               inf,
    input  logic               sel_action_valid,
    input  bev_pkg::action_t   action,
    input  logic               type_valid,
    input  bev_pkg::bev_type_t bev_type,
    input  logic               size_valid,
    input  bev_pkg::bev_size_t bev_size,
    input  logic               date_valid,
    input  bev_pkg::date_t     date,
    input  logic               box_no_valid,
    input  bev_pkg::box_no_t   box_no,
    input  logic               c_in_valid,
    input  bev_pkg::box_no_t   c_addr,
    input  logic               c_r_wb,
    input  bev_pkg::barrel_t   c_data_w,
    input  logic               c_out_valid,
    input  bev_pkg::barrel_t   c_data_r,
    input  logic               out_valid,
    input  bev_pkg::err_msg_t  err_msg,
    input  logic               complete,
    output int                 pass_cnt,
    output int                 fail_cnt
);

    bev_pkg::action_t   o_act;
    bev_pkg::bev_type_t o_type;
    bev_pkg::bev_size_t o_size;
    bev_pkg::date_t     o_date;
    bev_pkg::box_no_t   o_box;
    bev_pkg::box_no_t   rd_addr;
    bev_pkg::box_no_t   wr_addr;
    bev_pkg::barrel_t   rd_data;
    bev_pkg::barrel_t   wr_data;
    bev_pkg::barrel_t   shadow [256];
    bit                 known [256];
    bit                 was_up;
    bit                 bad;
    bit                 stray;
    int                 reads;
    int                 writes;
    int                 n_test;
    int                 n_pass;
    int                 n_fail;
    string              tname;

    assign pass_cnt = n_pass;
    assign fail_cnt = n_fail;

    function automatic bev_pkg::ing_t share(int cup, int num, int den);
        return bev_pkg::ing_t'(cup * num / den);
    endfunction

    // recipe table splitting the cup volume by type
    function automatic bev_pkg::recipe_t recipe(bev_pkg::bev_type_t t, bev_pkg::bev_size_t s);
        int               cup;
        bev_pkg::recipe_t r;
        cup = (s == bev_pkg::size_l) ? 960 : (s == bev_pkg::size_m) ? 720 : 480;
        r   = '0;
        case (t)
            bev_pkg::black_tea: r.black_tea = share(cup, 1, 1);
            bev_pkg::milk_tea: begin
                r.black_tea = share(cup, 3, 4);
                r.milk      = share(cup, 1, 4);
            end
            bev_pkg::extra_milk_tea: begin
                r.black_tea = share(cup, 1, 2);
                r.milk      = share(cup, 1, 2);
            end
            bev_pkg::green_tea: r.green_tea = share(cup, 1, 1);
            bev_pkg::green_milk_tea: begin
                r.green_tea = share(cup, 1, 2);
                r.milk      = share(cup, 1, 2);
            end
            bev_pkg::pineapple_juice: r.pineapple = share(cup, 1, 1);
            bev_pkg::super_pineapple_tea: begin
                r.black_tea = share(cup, 1, 2);
                r.pineapple = share(cup, 1, 2);
            end
            bev_pkg::super_pineapple_milk_tea: begin
                r.black_tea = share(cup, 1, 2);
                r.milk      = share(cup, 1, 4);
                r.pineapple = share(cup, 1, 4);
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic begin_test(input string name);
        tname = name;
        bad   = 1'b0;
    endtask

    // only the first mismatch of a test is reported
    task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (!bad && exp !== act) begin
            $display("Fail %s %s: expected %0h actual %0h", tname, what, exp, act);
            bad = 1'b1;
        end
    endtask

    task automatic end_test();
        if (bad) begin
            n_fail++;
        end else begin
            n_pass++;
            $display("Pass %s", tname);
        end
    endtask

    task automatic judge_order();
        bev_pkg::recipe_t  need;
        bev_pkg::barrel_t  exp_w;
        bev_pkg::err_msg_t exp_err;
        logic              late;
        logic              lack;
        need = recipe(o_type, o_size);
        // dates as day counts with 32 per month
        late = int'(o_date.month) * 32 + int'(o_date.day) >
               int'(rd_data.month) * 32 + int'(rd_data.day);
        lack = rd_data.black_tea < need.black_tea || rd_data.green_tea < need.green_tea ||
               rd_data.milk < need.milk || rd_data.pineapple < need.pineapple;
        if (late)
            exp_err = bev_pkg::no_exp;
        else if (o_act == bev_pkg::make_drink && lack)
            exp_err = bev_pkg::no_ing;
        else
            exp_err = bev_pkg::no_err;
        exp_w           = rd_data;
        exp_w.black_tea = rd_data.black_tea - need.black_tea;
        exp_w.green_tea = rd_data.green_tea - need.green_tea;
        exp_w.milk      = rd_data.milk - need.milk;
        exp_w.pineapple = rd_data.pineapple - need.pineapple;
        exp_w.pad_m     = '0;
        exp_w.pad_d     = '0;
        n_test++;
        begin_test($sformatf("order %0d %s", n_test, o_act.name()));
        compare("err_msg", 64'(exp_err), 64'(err_msg));
        compare("complete", 64'(exp_err == bev_pkg::no_err), 64'(complete));
        compare("read count", 64'(1), 64'(reads));
        compare("read box", 64'(o_box), 64'(rd_addr));
        if (known[o_box])
            compare("stored record", 64'(shadow[o_box]), 64'(rd_data));
        if (o_act == bev_pkg::make_drink && exp_err == bev_pkg::no_err) begin
            compare("write count", 64'(1), 64'(writes));
            compare("write box", 64'(o_box), 64'(wr_addr));
            compare("write data", 64'(exp_w), 64'(wr_data));
            shadow[o_box] = exp_w;
        end else begin
            compare("write count", 64'(0), 64'(writes));
            shadow[o_box] = rd_data;
        end
        compare("err_msg or complete set outside the response", 64'(0), 64'(stray));
        stray        = 1'b0;
        known[o_box] = 1'b1;
        end_test();
    endtask

    always @(posedge clk) begin
        if (inf && !was_up) begin
            begin_test("reset");
            compare("out_valid", 64'(0), 64'(out_valid));
            compare("c_in_valid", 64'(0), 64'(c_in_valid));
            compare("complete", 64'(0), 64'(complete));
            compare("c_r_wb", 64'(1), 64'(c_r_wb));
            compare("err_msg", 64'(bev_pkg::no_err), 64'(err_msg));
            end_test();
        end
        was_up = inf;
        if (inf) begin
            if (sel_action_valid) begin
                o_act  = action;
                reads  = 0;
                writes = 0;
            end
            if (type_valid)
                o_type = bev_type;
            if (size_valid)
                o_size = bev_size;
            if (date_valid)
                o_date = date;
            if (box_no_valid)
                o_box = box_no;
            if (c_in_valid && c_r_wb) begin
                reads++;
                rd_addr = c_addr;
            end
            if (c_in_valid && !c_r_wb) begin
                writes++;
                wr_addr = c_addr;
                wr_data = c_data_w;
            end
            if (c_out_valid && c_r_wb)
                rd_data = c_data_r;
            if (!out_valid && (err_msg != bev_pkg::no_err || complete))
                stray = 1'b1;
            if (out_valid)
                judge_order();
        end
    end

endmodule

// ==== sim/tb_bev.sv ====
`timescale 1ns/1ns

module tb_bev;

    localparam int n_orders   = 250;
    localparam int resp_limit = 100;

    logic               clk;
    logic               inf;
    logic               sel_action_valid;
    bev_pkg::action_t   action;
    logic               type_valid;
    bev_pkg::bev_type_t bev_type;
    logic               size_valid;
    bev_pkg::bev_size_t bev_size;
    logic               date_valid;
    bev_pkg::date_t     date;
    logic               box_no_valid;
    bev_pkg::box_no_t   box_no;
    logic               c_in_valid;
    bev_pkg::box_no_t   c_addr;
    logic               c_r_wb;
    bev_pkg::barrel_t   c_data_w;
    logic               c_out_valid;
    bev_pkg::barrel_t   c_data_r;
    logic               out_valid;
    bev_pkg::err_msg_t  err_msg;
    logic               complete;
    int                 pass_cnt;
    int                 fail_cnt;
    bit                 timed_out;
    bev_pkg::barrel_t   mem [256];

    bev_top uut (.*);

    bev_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic idle_gap();
        repeat ($urandom % 4) next_cycle();
    endtask

    // stock range is close to a large cup, so shortages come up
    task automatic fill_memory();
        for (int i = 0; i < 256; i++) begin
            mem[i]           = '0;
            mem[i].black_tea = bev_pkg::ing_t'($urandom % 1600);
            mem[i].green_tea = bev_pkg::ing_t'($urandom % 1600);
            mem[i].milk      = bev_pkg::ing_t'($urandom % 1600);
            mem[i].pineapple = bev_pkg::ing_t'($urandom % 1600);
            mem[i].month     = bev_pkg::month_t'(1 + $urandom % 12);
            mem[i].day       = bev_pkg::day_t'(1 + $urandom % 28);
        end
    endtask

    task automatic run_order();
        bev_pkg::action_t act;
        int               wait_cnt;
        act = ($urandom % 3 == 0) ? bev_pkg::check_valid_date : bev_pkg::make_drink;
        sel_action_valid = 1'b1;
        action           = act;
        next_cycle();
        sel_action_valid = 1'b0;
        idle_gap();
        if (act == bev_pkg::make_drink) begin
            type_valid = 1'b1;
            bev_type   = bev_pkg::bev_type_t'($urandom % 8);
            next_cycle();
            type_valid = 1'b0;
            idle_gap();
            size_valid = 1'b1;
            bev_size   = bev_pkg::bev_size_t'($urandom % 3);
            next_cycle();
            size_valid = 1'b0;
            idle_gap();
        end
        date_valid = 1'b1;
        date.month = bev_pkg::month_t'(1 + $urandom % 12);
        date.day   = bev_pkg::day_t'(1 + $urandom % 28);
        next_cycle();
        date_valid = 1'b0;
        idle_gap();
        // few boxes so that records get read again after a write
        box_no_valid = 1'b1;
        box_no       = bev_pkg::box_no_t'($urandom % 48);
        next_cycle();
        box_no_valid = 1'b0;
        wait_cnt     = 0;
        while (!out_valid && wait_cnt < resp_limit) begin
            next_cycle();
            wait_cnt++;
        end
        if (!out_valid) begin
            $display("timeout: no response pulse within %0d cycles of the box number", resp_limit);
            timed_out = 1'b1;
        end
        next_cycle();
        idle_gap();
    endtask

    // memory bridge model serving one request at a time
    initial begin : bridge
        bev_pkg::box_no_t addr;
        bev_pkg::barrel_t wdata;
        logic             rd;
        int               lat;
        forever begin
            next_cycle();
            if (inf && c_in_valid) begin
                addr  = c_addr;
                rd    = c_r_wb;
                wdata = c_data_w;
                lat   = 1 + $urandom % 8;
                repeat (lat - 1) next_cycle();
                c_out_valid = 1'b1;
                if (rd)
                    c_data_r = mem[addr];
                else
                    mem[addr] = wdata;
                next_cycle();
                c_out_valid = 1'b0;
            end
        end
    end

    initial begin
        void'($urandom(32'h906212c9));
        inf              = 1'b0;
        sel_action_valid = 1'b0;
        action           = bev_pkg::make_drink;
        type_valid       = 1'b0;
        bev_type         = bev_pkg::black_tea;
        size_valid       = 1'b0;
        bev_size         = bev_pkg::size_l;
        date_valid       = 1'b0;
        date             = '0;
        box_no_valid     = 1'b0;
        box_no           = '0;
        c_out_valid      = 1'b0;
        c_data_r         = '0;
        timed_out        = 1'b0;
        fill_memory();
        repeat (16) @(posedge clk);
        #10;
        inf = 1'b1;
        next_cycle();
        for (int n = 0; n < n_orders && !timed_out; n++)
            run_order();
        $display("summary: %0d tests ok, %0d tests with errors", pass_cnt, fail_cnt);
        if (!timed_out && fail_cnt == 0 && pass_cnt == n_orders + 1)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+source
source/bev_pkg.sv
source/bev_order_intake.sv
source/bev_barrel_calc.sv
source/bev_control.sv
source/bev_top.sv
sim/bev_checker.sv
sim/tb_bev.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_bev
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, then search the log for the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
